/* fe_front.f */
src/fe_pkg.sv
src/fe_ctrl.sv
src/fe_pc.sv
src/fe_dec_stage.sv
src/fe_top.sv
tests/fe_checker.sv
tests/fe_top_sva.sv
tests/tb_fe_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fe_top -f fe_front.f -o sim_fe \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_fe > sim.log 2>&1
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation did not finish, see sim.log"; exit 1; }

/* tests/tb_fe_top.sv */
`timescale 1ns/1ps

module tb_fe_top;

    import fe_pkg::*;

    localparam int ROWS = 12;
    localparam int WAIT_LIMIT = 200;
    localparam logic [1:0] KIND_ALU = 2'd0;
    localparam logic [1:0] KIND_BRANCH = 2'd1;
    localparam logic [1:0] KIND_JALR = 2'd2;
    localparam logic [1:0] KIND_JAL = 2'd3;
    localparam opcode_t OPC_ALU = 7'b011_0011;

    logic clk = 1'b0;
    logic rst;
    logic imem_req_ready = 1'b0;
    logic imem_rsp_valid = 1'b0;
    imem_rsp_t imem_rsp = '0;
    exe_res_t exe_res;
    logic dc_stalled;
    hazard_t hazard;
    logic imem_req_valid;
    imem_req_t imem_req;
    logic imem_rsp_ready;
    logic dec_valid;
    arch_width_t dec_pc;
    inst_t dec_inst;
    int err_cnt;
    int rows_done;

    // program table with one row per instruction in program order
    logic [1:0] kind_tbl [0:ROWS-1];
    logic taken_tbl [0:ROWS-1];
    arch_width_t target_tbl [0:ROWS-1];
    int lat_tbl [0:ROWS-1];
    int stall_tbl [0:ROWS-1];

    int seed;
    int acc_cnt;
    int busy_idx;
    int wait_cnt;
    logic busy;
    int k;
    int t;
    logic fired;
    logic timed_out;
    arch_width_t flow_pc;

    always #5 clk = ~clk;

    fe_top UUT (
        .clk            (clk),
        .rst            (rst),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp       (imem_rsp),
        .exe_res        (exe_res),
        .dc_stalled     (dc_stalled),
        .hazard         (hazard),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_rsp_ready (imem_rsp_ready),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_inst       (dec_inst)
    );

    fe_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req       (imem_req),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .imem_rsp       (imem_rsp),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_inst       (dec_inst),
        .dc_stalled     (dc_stalled),
        .hazard         (hazard),
        .kind_tbl       (kind_tbl),
        .taken_tbl      (taken_tbl),
        .target_tbl     (target_tbl),
        .err_cnt        (err_cnt),
        .rows_done      (rows_done)
    );

    task set_row(input int idx, input logic [1:0] kind, input logic taken,
                 input arch_width_t target, input int lat, input int stall);
        kind_tbl[idx] = kind;
        taken_tbl[idx] = taken;
        target_tbl[idx] = target;
        lat_tbl[idx] = lat;
        stall_tbl[idx] = stall;
    endtask

    function automatic opcode_t kind_opcode(input logic [1:0] kind);
        case (kind)
            KIND_BRANCH: kind_opcode = OPC_BRANCH;
            KIND_JALR: kind_opcode = OPC_JALR;
            KIND_JAL: kind_opcode = OPC_JAL;
            default: kind_opcode = OPC_ALU;
        endcase
    endfunction

    // row index in the upper bits keeps every returned word distinct
    function automatic inst_t make_inst(input int idx);
        make_inst = {idx[11:0], 13'd0, kind_opcode(kind_tbl[idx])};
    endfunction

    // instruction memory answers the n-th accepted request with row n
    always @(posedge clk) begin
        if (rst) begin
            imem_req_ready <= 1'b0;
            imem_rsp_valid <= 1'b0;
            imem_rsp <= '0;
            acc_cnt = 0;
            busy = 1'b0;
            wait_cnt = 0;
        end else begin
            if (imem_rsp_valid && imem_rsp_ready) begin
                imem_rsp_valid <= 1'b0;
            end
            if (busy) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    imem_rsp_valid <= 1'b1;
                    imem_rsp <= '{inst: make_inst(busy_idx)};
                    busy = 1'b0;
                end
            end
            if (imem_req_valid && imem_req_ready) begin
                busy_idx = acc_cnt;
                acc_cnt = acc_cnt + 1;
                // latency of zero in the table picks a random one
                if (lat_tbl[busy_idx] > 0) begin
                    wait_cnt = lat_tbl[busy_idx];
                end else begin
                    wait_cnt = 1 + int'($unsigned($random(seed)) % 4);
                end
                busy = 1'b1;
            end
            imem_req_ready <= (acc_cnt < ROWS);
        end
    end

    initial begin
        seed = 32'h5143;
        timed_out = 1'b0;
        set_row(0, KIND_ALU, 1'b0, 32'h0, 2, 0);
        set_row(1, KIND_ALU, 1'b0, 32'h0, 0, 0);
        set_row(2, KIND_ALU, 1'b0, 32'h0, 3, 3);
        set_row(3, KIND_BRANCH, 1'b1, 32'h0000_0300, 1, 0);
        set_row(4, KIND_ALU, 1'b0, 32'h0, 1, 0);
        set_row(5, KIND_BRANCH, 1'b0, 32'h0000_0400, 2, 0);
        set_row(6, KIND_ALU, 1'b0, 32'h0, 0, 2);
        set_row(7, KIND_ALU, 1'b0, 32'h0, 2, 2);
        set_row(8, KIND_JALR, 1'b1, 32'h0000_0500, 1, 0);
        set_row(9, KIND_ALU, 1'b0, 32'h0, 4, 0);
        set_row(10, KIND_JAL, 1'b1, 32'h0000_0280, 0, 0);
        set_row(11, KIND_ALU, 1'b0, 32'h0, 1, 0);
        rst = 1'b1;
        dc_stalled = 1'b0;
        hazard = '0;
        exe_res = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (k = 0; k < ROWS && !timed_out; k++) begin
            t = 0;
            fired = 1'b0;
            while (!fired && t < WAIT_LIMIT) begin
                @(posedge clk);
                fired = imem_rsp_valid && imem_rsp_ready;
                t++;
            end
            if (!fired) begin
                $display("timeout waiting for the response of row %0d", k);
                timed_out = 1'b1;
            end else if (kind_tbl[k] != KIND_ALU) begin
                // execute resolves two cycles after decode shows the flow inst
                @(posedge clk);
                flow_pc = dec_pc;
                @(posedge clk);
                exe_res <= '{pc_exe: flow_pc,
                             branch_in_exe: (kind_tbl[k] == KIND_BRANCH),
                             jalr_in_exe: (kind_tbl[k] != KIND_BRANCH),
                             taken: taken_tbl[k],
                             target: target_tbl[k]};
                @(posedge clk);
                exe_res <= '0;
            end else if (stall_tbl[k] > 0) begin
                // even rows stall on the data cache, odd rows on a hazard
                if (k % 2 == 0) begin
                    dc_stalled <= 1'b1;
                end else begin
                    hazard <= '{to_dec: 1'b0, to_exe: 1'b1};
                end
                repeat (stall_tbl[k]) @(posedge clk);
                dc_stalled <= 1'b0;
                hazard <= '0;
            end
        end

        t = 0;
        while (!timed_out && rows_done < ROWS && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (!timed_out && rows_done < ROWS) begin
            $display("timeout waiting for the last rows to reach decode");
            timed_out = 1'b1;
        end
        $display("rows %0d of %0d checked, %0d errors, %0d assertion failures",
                 rows_done, ROWS, err_cnt, UUT.u_sva.fail_cnt);
        if (timed_out || err_cnt != 0 || UUT.u_sva.fail_cnt != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

/* tests/fe_top_sva.sv */
`timescale 1ns/1ps

module fe_top_sva (
    input  logic clk,
    input  logic rst,
    input  logic imem_req_valid,
    input  logic imem_req_ready,
    input  fe_pkg::imem_req_t imem_req,
    input  logic dc_stalled,
    input  logic branch_in_dec,
    input  logic jalr_in_dec,
    input  fe_pkg::arch_width_t dec_pc,
    input  fe_pkg::exe_res_t exe_res,
    input  fe_pkg::hazard_t hazard
);

    import fe_pkg::*;

    logic flow_wait;
    arch_width_t wait_pc;
    int fail_cnt = 0;

    // open from a flow inst in decode until execute resolves it
    always_ff @(posedge clk) begin
        if (rst) begin
            flow_wait <= 1'b0;
            wait_pc <= '0;
        end else if (flow_wait && exe_res.pc_exe == wait_pc && exe_res.pc_exe != '0 &&
                     !hazard.to_exe) begin
            flow_wait <= 1'b0;
        end else if (branch_in_dec || jalr_in_dec) begin
            flow_wait <= 1'b1;
            wait_pc <= dec_pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req.addr))
        else begin
            fail_cnt++;
            $error("request dropped or moved before acceptance");
        end

    assert property (@(posedge clk) disable iff (rst) dc_stalled |-> !imem_req_valid)
        else begin
            fail_cnt++;
            $error("request raised while the data cache stalls");
        end

    assert property (@(posedge clk) disable iff (rst)
        flow_wait || branch_in_dec || jalr_in_dec |-> !imem_req_valid)
        else begin
            fail_cnt++;
            $error("request raised before the flow inst was resolved");
        end

endmodule

bind fe_top fe_top_sva u_sva (
    .clk            (clk),
    .rst            (rst),
    .imem_req_valid (imem_req_valid),
    .imem_req_ready (imem_req_ready),
    .imem_req       (imem_req),
    .dc_stalled     (dc_stalled),
    .branch_in_dec  (branch_in_dec),
    .jalr_in_dec    (jalr_in_dec),
    .dec_pc         (dec_pc),
    .exe_res        (exe_res),
    .hazard         (hazard)
);

/* tests/fe_checker.sv */
`timescale 1ns/1ps

module fe_checker (
    input  logic clk,
    input  logic rst,
    input  logic imem_req_valid,
    input  logic imem_req_ready,
    input  fe_pkg::imem_req_t imem_req,
    input  logic imem_rsp_valid,
    input  logic imem_rsp_ready,
    input  fe_pkg::imem_rsp_t imem_rsp,
    input  logic dec_valid,
    input  fe_pkg::arch_width_t dec_pc,
    input  fe_pkg::inst_t dec_inst,
    input  logic dc_stalled,
    input  fe_pkg::hazard_t hazard,
    input  logic [1:0] kind_tbl [0:11],
    input  logic taken_tbl [0:11],
    input  fe_pkg::arch_width_t target_tbl [0:11],
    output int err_cnt,
    output int rows_done
);

    import fe_pkg::*;

    localparam int ROWS = 12;

    arch_width_t exp_addr;
    arch_width_t exp_pc [0:ROWS-1];
    int req_seen;
    int rsp_seen;
    int row_base;
    int due_row;
    logic dec_due;
    inst_t due_inst;
    logic be;
    logic stall_prev;
    arch_width_t held_pc;
    inst_t held_inst;

    // address that follows a row in program order
    function automatic arch_width_t next_addr(input int row, input arch_width_t addr);
        if (kind_tbl[row] == 2'd0) begin
            next_addr = addr + 32'd4;
        end else if (kind_tbl[row] == 2'd1 && !taken_tbl[row]) begin
            next_addr = addr + 32'd4;
        end else begin
            next_addr = target_tbl[row];
        end
    endfunction

    task compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("error %s exp %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            err_cnt = 0;
            rows_done = 0;
            req_seen = 0;
            rsp_seen = 0;
            row_base = 0;
            dec_due = 1'b0;
            stall_prev = 1'b0;
            exp_addr = RESET_VEC;
        end else begin
            if (dec_due) begin
                compare("dec_valid", 32'd1, {31'd0, dec_valid});
                compare("dec_pc", exp_pc[due_row], dec_pc);
                compare("dec_inst", due_inst, dec_inst);
                $display("row %0d pc %h inst %h %s", due_row, dec_pc, dec_inst,
                         (err_cnt == row_base) ? "ok" : "bad");
                row_base = err_cnt;
                rows_done++;
                dec_due = 1'b0;
            end
            if (rsp_seen == 0 && dec_valid) begin
                $display("decode went valid before the first response arrived");
                err_cnt++;
            end
            // decode must not move across a back-end stall cycle
            if (stall_prev) begin
                compare("dec_pc", held_pc, dec_pc);
                compare("dec_inst", held_inst, dec_inst);
            end
            be = dc_stalled || hazard.to_exe;
            // no response is taken while the back end is full
            if (be) begin
                compare("imem_rsp_ready", 32'd0, {31'd0, imem_rsp_ready});
            end
            if (imem_req_valid && imem_req_ready) begin
                if (be) begin
                    $display("a request was accepted during a back-end stall");
                    err_cnt++;
                end
                if (req_seen < ROWS) begin
                    compare("imem_req.addr", exp_addr, imem_req.addr);
                    exp_pc[req_seen] = exp_addr;
                    exp_addr = next_addr(req_seen, exp_addr);
                end
                req_seen++;
            end
            if (imem_rsp_valid && imem_rsp_ready) begin
                dec_due = 1'b1;
                due_row = rsp_seen;
                due_inst = imem_rsp.inst;
                rsp_seen++;
            end
            stall_prev = be;
            held_pc = dec_pc;
            held_inst = dec_inst;
        end
    end

endmodule

/* src/fe_top.sv */
`timescale 1ns/1ps

module fe_top (
    input  logic clk,
    input  logic rst,
    input  logic imem_req_ready,
    input  logic imem_rsp_valid,
    input  fe_pkg::imem_rsp_t imem_rsp,
    input  fe_pkg::exe_res_t exe_res,
    input  logic dc_stalled,
    input  fe_pkg::hazard_t hazard,
    output logic imem_req_valid,
    output fe_pkg::imem_req_t imem_req,
    output logic imem_rsp_ready,
    output logic dec_valid,
    output fe_pkg::arch_width_t dec_pc,
    output fe_pkg::inst_t dec_inst
);

    import fe_pkg::*;

    fe_ctrl_t fe_ctrl;
    fe_ctrl_t decoded_fe_ctrl;
    arch_width_t redirect;
    arch_width_t pc;
    logic branch_in_dec;
    logic jalr_in_dec;
    logic rsp_fire;

    assign rsp_fire = imem_rsp_valid && imem_rsp_ready;
    assign imem_req.addr = pc;

    fe_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .imem_req_ready  (imem_req_ready),
        .imem_rsp_valid  (imem_rsp_valid),
        .dec_pc          (dec_pc),
        .branch_in_dec   (branch_in_dec),
        .jalr_in_dec     (jalr_in_dec),
        .exe_res         (exe_res),
        .dc_stalled      (dc_stalled),
        .hazard          (hazard),
        .decoded_fe_ctrl (decoded_fe_ctrl),
        .imem_req_valid  (imem_req_valid),
        .imem_rsp_ready  (imem_rsp_ready),
        .fe_ctrl         (fe_ctrl),
        .redirect        (redirect)
    );

    fe_pc u_pc (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (fe_ctrl),
        .redirect (redirect),
        .pc       (pc)
    );

    fe_dec_stage u_dec (
        .clk             (clk),
        .rst             (rst),
        .rsp             (imem_rsp),
        .rsp_fire        (rsp_fire),
        .pc_fetch        (pc),
        .bubble          (fe_ctrl.bubble_dec),
        .dec_valid       (dec_valid),
        .dec_pc          (dec_pc),
        .dec_inst        (dec_inst),
        .branch_in_dec   (branch_in_dec),
        .jalr_in_dec     (jalr_in_dec),
        .decoded_fe_ctrl (decoded_fe_ctrl)
    );

endmodule

/* src/fe_dec_stage.sv */
`timescale 1ns/1ps

module fe_dec_stage (
    input  logic clk,
    input  logic rst,
    input  fe_pkg::imem_rsp_t rsp,
    input  logic rsp_fire,
    input  fe_pkg::arch_width_t pc_fetch,
    input  logic bubble,
    output logic dec_valid,
    output fe_pkg::arch_width_t dec_pc,
    output fe_pkg::inst_t dec_inst,
    output logic branch_in_dec,
    output logic jalr_in_dec,
    output fe_pkg::fe_ctrl_t decoded_fe_ctrl
);

    import fe_pkg::*;

    opcode_t opc;
    logic is_branch;
    logic is_jump;
    logic branch_q;
    logic jump_q;

    // predecode of the returning instruction, jal handled like jalr
    assign opc = rsp.inst[6:0];
    assign is_branch = (opc == OPC_BRANCH);
    assign is_jump = (opc == OPC_JALR) || (opc == OPC_JAL);

    always_comb begin
        decoded_fe_ctrl = '{pc_sel: PC_SEL_INC4, pc_we: 1'b1, bubble_dec: 1'b0};
        if (is_branch || is_jump) begin
            decoded_fe_ctrl.pc_sel = PC_SEL_PC;
            decoded_fe_ctrl.pc_we = 1'b0;
        end
    end

    // capture wins over bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (rsp_fire) begin
            dec_valid <= 1'b1;
        end else if (bubble) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            dec_inst <= rsp.inst;
            // fetch pc has already stepped past the request in flight
            dec_pc <= pc_fetch - INST_BYTES;
            branch_q <= is_branch;
            jump_q <= is_jump;
        end
    end

    assign branch_in_dec = dec_valid && branch_q;
    assign jalr_in_dec = dec_valid && jump_q;

endmodule

/* src/fe_pc.sv */
`timescale 1ns/1ps

module fe_pc (
    input  logic clk,
    input  logic rst,
    input  fe_pkg::fe_ctrl_t ctrl,
    input  fe_pkg::arch_width_t redirect,
    output fe_pkg::arch_width_t pc
);

    import fe_pkg::*;

    arch_width_t pc_nx;

    // next fetch address
    always_comb begin
        unique case (ctrl.pc_sel)
            PC_SEL_INC4: begin
                pc_nx = pc + INST_BYTES;
            end
            PC_SEL_ALU: begin
                pc_nx = redirect;
            end
            default: begin
                pc_nx = pc;
            end
        endcase
    end

    // pc always points at the next address to request
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (ctrl.pc_we) begin
            pc <= pc_nx;
        end
    end

endmodule

/* src/fe_ctrl.sv */
`timescale 1ns/1ps

module fe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic imem_req_ready,
    input  logic imem_rsp_valid,
    input  fe_pkg::arch_width_t dec_pc,
    input  logic branch_in_dec,
    input  logic jalr_in_dec,
    input  fe_pkg::exe_res_t exe_res,
    input  logic dc_stalled,
    input  fe_pkg::hazard_t hazard,
    input  fe_pkg::fe_ctrl_t decoded_fe_ctrl,
    output logic imem_req_valid,
    output logic imem_rsp_ready,
    output fe_pkg::fe_ctrl_t fe_ctrl,
    output fe_pkg::arch_width_t redirect
);

    import fe_pkg::*;

    typedef enum logic [2:0] {
        RST,
        STEADY,
        STALL_FLOW,
        STALL_FE_IC,
        STALL_BE
    } stall_state_t;

    // flow instruction parked in decode, waiting on execute
    typedef struct packed {
        logic jump;
        arch_width_t pc;
    } stalled_entry_t;

    stall_state_t state;
    stall_state_t nx_state;
    stalled_entry_t stalled_entry;
    fe_ctrl_t ctrl_base;
    logic be_act;
    logic flow_act;
    logic flow_res;
    logic flow_taken;
    logic save_entry;
    logic req_fire;
    logic rsp_fire;
    logic outstanding;
    logic req_wait;

    // stall sources
    assign be_act = dc_stalled || hazard.to_exe;
    assign flow_act = branch_in_dec || jalr_in_dec;

    // execute has reached the parked instruction
    assign flow_res = (stalled_entry.pc == exe_res.pc_exe) && (exe_res.pc_exe != '0) &&
                      !hazard.to_exe;

    // jumps always leave the sequential path, branches only when taken
    assign flow_taken = stalled_entry.jump || exe_res.jalr_in_exe ||
                        (exe_res.branch_in_exe && exe_res.taken);
    assign redirect = flow_taken ? exe_res.target : stalled_entry.pc + INST_BYTES;

    assign req_fire = imem_req_valid && imem_req_ready;
    assign rsp_fire = imem_rsp_valid && imem_rsp_ready;

    always_comb begin
        nx_state = state;
        ctrl_base = FE_CTRL_INIT;
        save_entry = 1'b0;
        imem_rsp_ready = 1'b0;
        // a request already on the bus stays there until memory takes it
        imem_req_valid = req_wait;

        unique case (state)
            RST: begin
                // boot fetch at the reset vector, memory may still be cold
                imem_req_valid = 1'b1;
                if (imem_req_ready) begin
                    nx_state = STALL_FE_IC;
                end
            end

            STALL_FLOW: begin
                // decode stays empty until execute resolves
                if (flow_res) begin
                    ctrl_base.pc_sel = PC_SEL_ALU;
                    ctrl_base.pc_we = 1'b1;
                    nx_state = STEADY;
                end
            end

            STEADY, STALL_FE_IC, STALL_BE: begin
                ctrl_base.bubble_dec = 1'b0;
                if (be_act) begin
                    // back end is full, freeze fetch and decode
                    nx_state = STALL_BE;
                end else if (flow_act) begin
                    // branch or jump visible in decode for one cycle
                    save_entry = 1'b1;
                    nx_state = STALL_FLOW;
                end else begin
                    imem_rsp_ready = 1'b1;
                    // next request rides along with the response of an ordinary inst
                    imem_req_valid = req_wait || !outstanding ||
                                     (imem_rsp_valid && decoded_fe_ctrl.pc_we);
                    // nothing came back this cycle, decode goes empty
                    ctrl_base.bubble_dec = !imem_rsp_valid;
                    nx_state = imem_rsp_valid ? STEADY : STALL_FE_IC;
                end
            end

            default: ;
        endcase
    end

    // pc steps past every request memory accepts
    always_comb begin
        fe_ctrl = ctrl_base;
        if (req_fire) begin
            fe_ctrl.pc_sel = PC_SEL_INC4;
            fe_ctrl.pc_we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
            outstanding <= 1'b0;
            req_wait <= 1'b0;
        end else begin
            state <= nx_state;
            outstanding <= req_fire || (outstanding && !rsp_fire);
            req_wait <= imem_req_valid && !imem_req_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stalled_entry <= '0;
        end else if (save_entry) begin
            stalled_entry <= '{jump: jalr_in_dec, pc: dec_pc};
        end else if ((state == STALL_FLOW) && flow_res) begin
            stalled_entry <= '0;
        end
    end

endmodule

/* src/fe_pkg.sv */
package fe_pkg;

    // meaningful widths
    typedef logic [31:0] arch_width_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;

    // first fetch address, pc of zero is reserved for "no entry"
    localparam arch_width_t RESET_VEC = 32'h0000_0200;
    localparam arch_width_t INST_BYTES = 32'd4;

    // rv32 major opcodes seen by predecode
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JALR = 7'b110_0111;
    localparam opcode_t OPC_JAL = 7'b110_1111;

    typedef enum logic [1:0] {
        PC_SEL_PC,
        PC_SEL_INC4,
        PC_SEL_ALU
    } pc_sel_t;

    typedef struct packed {
        pc_sel_t pc_sel;
        logic pc_we;
        logic bubble_dec;
    } fe_ctrl_t;

    // hold pc, no write, decode bubbled
    localparam fe_ctrl_t FE_CTRL_INIT = '{pc_sel: PC_SEL_PC, pc_we: 1'b0, bubble_dec: 1'b1};

    typedef struct packed {
        arch_width_t addr;
    } imem_req_t;

    typedef struct packed {
        inst_t inst;
    } imem_rsp_t;

    // flow change as resolved by execute
    typedef struct packed {
        arch_width_t pc_exe;
        logic branch_in_exe;
        logic jalr_in_exe;
        logic taken;
        arch_width_t target;
    } exe_res_t;

    typedef struct packed {
        logic to_dec;
        logic to_exe;
    } hazard_t;

endpackage
